/* list.f */
vgaPkg.sv
gamePkg.sv
vgaTiming.sv
buttonDebounce.sv
shipControl.sv
bulletControl.sv
invaderMarch.sv
stateArbiter.sv
pixelRender.sv
spaceGameTop.sv
tbSpaceGame.sv

/* run.sh */
#!/bin/sh
# Build and run the space game testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tbSpaceGame -f list.f -o simSpaceGame
./obj_dir/simSpaceGame | tee sim.log
if grep -q "all tests passed" sim.log; then
   exit 0
else
   exit 1
fi

/* tbSpaceGame.sv */
// Space game testbench
`timescale 1ns/1ps

module tbSpaceGame import vgaPkg::*; ();

   localparam int H_TOTAL  = 80;                     // 64 + 4 + 8 + 4
   localparam int V_BACK   = 2;
   localparam int LAST_OFF = (V_BACK + 60) * H_TOTAL + 60;   // Last cell centre
   localparam int LIMIT    = 2 * H_TOTAL * 70;       // Two frames
   localparam logic [2:0] B_NONE = 0, B_LEFT = 1, B_RIGHT = 2, B_FIRE = 3, B_SHORT = 4;

   logic dclk, rstN, left, right, fire;
   logic hsync, vsync, red, green, blue;

   // One table row holds button, extra frames and expected state of the sampled frame
   typedef struct packed {
      logic [2:0] btn;
      logic [3:0] frames;
      logic [2:0] ship;
      logic [2:0] invRow;
      logic [7:0] mask;
      logic       fly;
      logic [2:0] bRow;
      logic [2:0] bCol;
   } stimRow_t;

   stimRow_t    stim [$];
   rgb_t        captured [8][8];     // Cell centre colours of one frame
   int          valueErrors, timeoutErrors;
   logic [31:0] rngState;
   logic [2:0]  shipModel;
   stimRow_t    row;

   spaceGameTop #(
      .H_ACTIVE(64), .H_FRONT(4), .H_SYNC(8), .H_BACK(4),
      .V_ACTIVE(64), .V_FRONT(2), .V_SYNC(2), .V_BACK(V_BACK),
      .CELL_SHIFT(3), .DEBOUNCE_CYCLES(4), .MARCH_FRAMES(4)
   ) dut_i (
      .dclk(dclk), .rstN(rstN), .left(left), .right(right), .fire(fire),
      .hsync(hsync), .vsync(vsync), .red(red), .green(green), .blue(blue));

   always #5 dclk = ~dclk;      // 10 ns period

   //////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Ship over bullet over invader
   function automatic rgb_t expectedColour(input int r, input int c, input stimRow_t e);
      if (r == 7 && c == e.ship) return 3'b010;
      if (e.fly && r == e.bRow && c == e.bCol) return 3'b111;
      if (r == e.invRow && e.mask[c]) return 3'b100;
      return 3'b000;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         valueErrors++;
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic addRow(input logic [2:0] btn, input logic [3:0] frames, input logic [2:0] ship,
                         input logic [2:0] inv, input logic [7:0] mask, input logic fly,
                         input logic [2:0] bRow, input logic [2:0] bCol);
      stim.push_back(stimRow_t'{btn, frames, ship, inv, mask, fly, bRow, bCol});
   endtask

   task automatic pressButton(input logic [2:0] btn);
      int hold;
      hold = (btn == B_SHORT) ? 2 : 8;            // Short press under debounce
      if (btn == B_NONE) return;
      @(negedge dclk);
      left  = (btn == B_LEFT);
      right = (btn == B_RIGHT) || (btn == B_SHORT);
      fire  = (btn == B_FIRE);
      repeat (hold) @(negedge dclk);
      left  = 1'b0;
      right = 1'b0;
      fire  = 1'b0;
   endtask

   task automatic waitVsyncRise();
      int n;
      n = 0;
      while (vsync !== 1'b0 && n < LIMIT) begin
         @(negedge dclk);
         n++;
      end
      if (n >= LIMIT) begin
         timeoutErrors++;
         $display("Timed out waiting for vsync to go low");
         return;
      end
      n = 0;
      while (vsync !== 1'b1 && n < LIMIT) begin
         @(negedge dclk);
         n++;
      end
      if (n >= LIMIT) begin
         timeoutErrors++;
         $display("Timed out waiting for vsync to go high");
      end
   endtask

   // Offset 0 is the cycle where vsync rose and lies two back-porch lines before line 0
   task automatic captureFrame();
      int x, y;
      for (int off = 0; off <= LAST_OFF; off++) begin
         y = off / H_TOTAL - V_BACK;
         x = off % H_TOTAL;
         if (y >= 0 && y % 8 == 4 && x < 64 && x % 8 == 4) begin
            captured[y / 8][x / 8] = {red, green, blue};
         end
         @(negedge dclk);
      end
   endtask

   task automatic applyRow(input stimRow_t e);
      pressButton(e.btn);
      repeat (e.frames) waitVsyncRise();
      waitVsyncRise();
      captureFrame();
      for (int r = 0; r < 8; r++)
         for (int c = 0; c < 8; c++)
            checkValue($sformatf("rgb cell r%0d c%0d", r, c), captured[r][c],
                       expectedColour(r, c, e));
   endtask

   //////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////

   initial begin
      int n;
      dclk = 1'b0;
      rstN = 1'b0;
      left = 1'b0;
      right = 1'b0;
      fire = 1'b0;
      valueErrors = 0;
      timeoutErrors = 0;
      rngState = 32'd43;
      // Comments give the sampled frame number
      addRow(B_NONE,  0, 0, 0, 8'hff, 0, 0, 0);   // F2 reset picture
      addRow(B_LEFT,  0, 0, 0, 8'hff, 0, 0, 0);   // Left edge holds
      addRow(B_RIGHT, 0, 1, 1, 8'hff, 0, 0, 0);   // F4 first descent
      addRow(B_RIGHT, 0, 2, 1, 8'hff, 0, 0, 0);
      addRow(B_SHORT, 0, 2, 1, 8'hff, 0, 0, 0);   // Bounce ignored
      addRow(B_LEFT,  0, 1, 1, 8'hff, 0, 0, 0);
      addRow(B_RIGHT, 0, 2, 2, 8'hff, 0, 0, 0);
      addRow(B_RIGHT, 0, 3, 2, 8'hff, 0, 0, 0);
      addRow(B_RIGHT, 0, 4, 2, 8'hff, 0, 0, 0);
      addRow(B_RIGHT, 0, 5, 2, 8'hff, 0, 0, 0);
      addRow(B_RIGHT, 0, 6, 3, 8'hff, 0, 0, 0);
      addRow(B_RIGHT, 0, 7, 3, 8'hff, 0, 0, 0);
      addRow(B_RIGHT, 0, 7, 3, 8'hff, 0, 0, 0);   // F14 right edge holds
      addRow(B_FIRE,  0, 7, 3, 8'hff, 1, 5, 7);   // Launched, one climb
      addRow(B_FIRE,  0, 7, 4, 8'hff, 1, 4, 7);   // Second fire ignored
      addRow(B_NONE,  0, 7, 4, 8'hff, 1, 3, 7);   // Slipped past descending row
      addRow(B_NONE,  3, 7, 5, 8'hff, 0, 0, 0);   // F21 gone off the top
      addRow(B_FIRE,  0, 7, 5, 8'h7f, 0, 0, 0);   // F22 hit clears column 7
      addRow(B_FIRE,  0, 7, 5, 8'h7f, 1, 5, 7);   // Under a dead column
      addRow(B_NONE,  0, 7, 6, 8'h7f, 1, 4, 7);
      addRow(B_NONE,  3, 7, 6, 8'h7f, 1, 0, 7);   // F28 top row
      addRow(B_NONE,  0, 7, 6, 8'h7f, 0, 0, 0);   // Vanished
      addRow(B_NONE,  4, 7, 6, 8'h7f, 0, 0, 0);   // F34 invaders stopped
      repeat (2) @(negedge dclk);
      rstN = 1'b1;
      // Hsync must pulse here
      n = 0;
      while (hsync !== 1'b0 && n < LIMIT) begin
         @(negedge dclk);
         n++;
      end
      if (n >= LIMIT) begin
         timeoutErrors++;
         $display("Timed out waiting for hsync to go low");
      end
      n = 0;
      while (hsync !== 1'b1 && n < LIMIT) begin
         @(negedge dclk);
         n++;
      end
      if (n >= LIMIT) begin
         timeoutErrors++;
         $display("Timed out waiting for hsync to go high");
      end
      foreach (stim[i]) applyRow(stim[i]);
      // Random left and right run against a saturating model
      shipModel = 3'd7;
      for (int i = 0; i < 12; i++) begin
         rngState = xorshift(rngState);
         if (rngState[0]) begin
            row.btn = B_LEFT;
            if (shipModel != 0) shipModel = shipModel - 1'b1;
         end else begin
            row.btn = B_RIGHT;
            if (shipModel != 7) shipModel = shipModel + 1'b1;
         end
         row = '{row.btn, 4'd0, shipModel, 3'd6, 8'h7f, 1'b0, 3'd0, 3'd0};
         applyRow(row);
      end
      $display("Errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
      if (valueErrors == 0 && timeoutErrors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // Overall run limit
   initial begin
      #10_000_000;
      $display("Simulation ran past its time limit");
      $display("tests failed");
      $finish;
   end

endmodule

/* spaceGameTop.sv */
// Space invaders VGA top level
`timescale 1ns/1ps

module spaceGameTop import vgaPkg::*, gamePkg::*; #(
   parameter int H_ACTIVE        = 64,
   parameter int H_FRONT         = 4,
   parameter int H_SYNC          = 8,
   parameter int H_BACK          = 4,
   parameter int V_ACTIVE        = 64,
   parameter int V_FRONT         = 2,
   parameter int V_SYNC          = 2,
   parameter int V_BACK          = 2,
   parameter int CELL_SHIFT      = 3,
   parameter int DEBOUNCE_CYCLES = 4,
   parameter int MARCH_FRAMES    = 4
) (
   input  logic dclk,     // Pixel clock
   input  logic rstN,
   input  logic left,
   input  logic right,
   input  logic fire,
   output logic hsync,
   output logic vsync,
   output logic red,
   output logic green,
   output logic blue
);

   screenPos_t         pos;
   logic               active, hsyncRaw, vsyncRaw, frameStart;
   logic               leftPulse, rightPulse, firePulse;
   gameState_t         state;
   logic [N_PEERS-1:0] peerValid, peerReady;   // 0 ship, 1 bullet, 2 march
   stateUpdate_t       peerUpd [N_PEERS];
   rgb_t               rgb;

   vgaTiming #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) timing (
      .dclk(dclk), .rstN(rstN), .pos(pos), .active(active),
      .hsync(hsyncRaw), .vsync(vsyncRaw), .frameStart(frameStart)
   );

   //////////////////////////////////////////
   // Buttons and game peers
   //////////////////////////////////////////

   buttonDebounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) leftDebounce (
      .dclk(dclk), .rstN(rstN), .button(left), .pressed(leftPulse));
   buttonDebounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) rightDebounce (
      .dclk(dclk), .rstN(rstN), .button(right), .pressed(rightPulse));
   buttonDebounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) fireDebounce (
      .dclk(dclk), .rstN(rstN), .button(fire), .pressed(firePulse));

   shipControl ship (
      .dclk(dclk), .rstN(rstN), .left(leftPulse), .right(rightPulse), .state(state),
      .updValid(peerValid[0]), .upd(peerUpd[0]), .updReady(peerReady[0]));

   bulletControl bullet (
      .dclk(dclk), .rstN(rstN), .fire(firePulse), .frameStart(frameStart), .state(state),
      .updValid(peerValid[1]), .upd(peerUpd[1]), .updReady(peerReady[1]));

   invaderMarch #(.MARCH_FRAMES(MARCH_FRAMES)) march (
      .dclk(dclk), .rstN(rstN), .frameStart(frameStart), .state(state),
      .updValid(peerValid[2]), .upd(peerUpd[2]), .updReady(peerReady[2]));

   stateArbiter arbiter (
      .dclk(dclk), .rstN(rstN), .reqValid(peerValid), .req(peerUpd),
      .reqReady(peerReady), .state(state));

   pixelRender #(.CELL_SHIFT(CELL_SHIFT)) render (
      .dclk(dclk), .rstN(rstN), .pos(pos), .active(active),
      .hsyncIn(hsyncRaw), .vsyncIn(vsyncRaw), .state(state),
      .rgb(rgb), .hsync(hsync), .vsync(vsync));

   assign red   = rgb[2];
   assign green = rgb[1];
   assign blue  = rgb[0];

endmodule

/* pixelRender.sv */
// Cell painter for the game screen
`timescale 1ns/1ps

module pixelRender import vgaPkg::*, gamePkg::*; #(
   parameter int CELL_SHIFT = 3
) (
   input  logic       dclk,
   input  logic       rstN,
   input  screenPos_t pos,
   input  logic       active,
   input  logic       hsyncIn,
   input  logic       vsyncIn,
   input  gameState_t state,
   output rgb_t       rgb,
   output logic       hsync,
   output logic       vsync
);

   logic [POS_BITS-1:0] cellX, cellY;     // Unclipped cell coordinates
   logic [COL_BITS-1:0] col;
   logic [ROW_BITS-1:0] row;
   logic                inGrid;
   rgb_t                colour;

   assign cellX  = pos.x >> CELL_SHIFT;
   assign cellY  = pos.y >> CELL_SHIFT;
   assign col    = cellX[COL_BITS-1:0];
   assign row    = cellY[ROW_BITS-1:0];
   assign inGrid = (cellX < POS_BITS'(INV_COLS)) && (cellY < POS_BITS'(1 << ROW_BITS));

   // Ship over bullet over invader
   always_comb begin
      colour = BLACK;
      if (active && inGrid) begin
         if (row == SHIP_ROW && col == state.shipCol) begin
            colour = GREEN;
         end else if (state.bulletFlying && row == state.bulletRow
                      && col == state.bulletCol) begin
            colour = WHITE;
         end else if (row == state.invRow && state.invArray[col]) begin
            colour = RED;
         end
      end
   end

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         rgb   <= BLACK;
         hsync <= 1'b1;
         vsync <= 1'b1;
      end else begin
         rgb   <= colour;
         hsync <= hsyncIn;   // Match the colour register
         vsync <= vsyncIn;
      end
   end

endmodule

/* stateArbiter.sv */
// Round-robin owner of the game record
`timescale 1ns/1ps

module stateArbiter import gamePkg::*; (
   input  logic               dclk,
   input  logic               rstN,
   input  logic [N_PEERS-1:0] reqValid,
   input  stateUpdate_t       req [N_PEERS],
   output logic [N_PEERS-1:0] reqReady,
   output gameState_t         state
);

   localparam int PTR_BITS = (N_PEERS > 1) ? $clog2(N_PEERS) : 1;

   logic [PTR_BITS-1:0] lastWinner;   // Search starts just after this peer
   logic [PTR_BITS-1:0] winner;
   logic                grantAny;
   stateUpdate_t        win;

   //////////////////////////////////////////
   // Grant select
   //////////////////////////////////////////

   always_comb begin
      int idx;
      winner   = lastWinner;
      grantAny = 1'b0;
      reqReady = '0;
      for (int off = 1; off <= N_PEERS; off++) begin
         idx = int'(lastWinner) + off;
         if (idx >= N_PEERS) idx = idx - N_PEERS;    // Wrap around
         if (!grantAny && reqValid[idx]) begin
            grantAny = 1'b1;
            winner   = PTR_BITS'(idx);
         end
      end
      if (grantAny) reqReady[winner] = 1'b1;
   end

   assign win = req[winner];

   //////////////////////////////////////////
   // Record update
   //////////////////////////////////////////

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         lastWinner <= PTR_BITS'(N_PEERS - 1);       // Peer 0 first after reset
         state      <= GAME_RESET;
      end else if (grantAny) begin
         lastWinner <= winner;
         unique case (win.field)
            F_SHIP:    state.shipCol <= win.value[COL_BITS-1:0];
            F_BULLET: begin
               state.bulletFlying <= win.value[6];
               state.bulletRow    <= win.value[5:3];
               state.bulletCol    <= win.value[2:0];
            end
            F_INVROW:  state.invRow <= win.value[ROW_BITS-1:0];
            F_INVKILL: state.invArray[win.value[COL_BITS-1:0]] <= 1'b0;
         endcase
      end
   end

endmodule

/* invaderMarch.sv */
// Invader row descent
`timescale 1ns/1ps

module invaderMarch import gamePkg::*; #(
   parameter int MARCH_FRAMES = 4
) (
   input  logic         dclk,
   input  logic         rstN,
   input  logic         frameStart,
   input  gameState_t   state,
   output logic         updValid,
   output stateUpdate_t upd,
   input  logic         updReady
);

   localparam int CNT_BITS = $clog2(MARCH_FRAMES + 1);

   logic [CNT_BITS-1:0] frameCnt;
   logic                stepDue;    // Descent owed but not yet requested

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         frameCnt <= '0;
         stepDue  <= 1'b0;
         updValid <= 1'b0;
         upd      <= '0;
      end else begin
         if (updValid) begin
            if (updReady) updValid <= 1'b0;
         end else if (stepDue) begin
            stepDue <= 1'b0;
            if (state.invRow < INV_STOP_ROW) begin   // Halt at the bottom
               updValid <= 1'b1;
               upd      <= {F_INVROW, 6'd0, state.invRow + 3'd1};
            end
         end
         if (frameStart) begin
            if (frameCnt == CNT_BITS'(MARCH_FRAMES - 1)) begin
               frameCnt <= '0;
               stepDue  <= 1'b1;       // Pending step just stays owed
            end else begin
               frameCnt <= frameCnt + 1'b1;
            end
         end
      end
   end

endmodule

/* bulletControl.sv */
// Bullet launch, climb and hit sequencing
`timescale 1ns/1ps

module bulletControl import gamePkg::*; (
   input  logic         dclk,
   input  logic         rstN,
   input  logic         fire,         // Debounced pulse
   input  logic         frameStart,
   input  gameState_t   state,
   output logic         updValid,
   output stateUpdate_t upd,
   input  logic         updReady
);

   typedef enum logic [2:0] {IDLE, LAUNCH, CLIMB, KILL, STOP} bulletFsm_t;

   bulletFsm_t          fsm;
   logic [ROW_BITS-1:0] nextRow;
   logic                hitNext;

   assign nextRow = state.bulletRow - 1'b1;
   assign hitNext = (nextRow == state.invRow) && state.invArray[state.bulletCol];

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         fsm      <= IDLE;
         updValid <= 1'b0;
         upd      <= '0;
      end else begin
         unique case (fsm)
            IDLE: if (fire && !state.bulletFlying) begin
               updValid <= 1'b1;
               upd      <= {F_BULLET, 2'b00, 1'b1, LAUNCH_ROW, state.shipCol};
               fsm      <= LAUNCH;
            end
            LAUNCH: if (updReady) begin
               updValid <= 1'b0;
               fsm      <= CLIMB;
            end
            CLIMB: if (updValid) begin
               if (updReady) updValid <= 1'b0;      // Step taken
            end else if (frameStart) begin         // One row per frame
               updValid <= 1'b1;
               if (state.bulletRow == '0) begin    // Off the top
                  upd <= {F_BULLET, 9'd0};
                  fsm <= STOP;
               end else if (hitNext) begin
                  upd <= {F_INVKILL, 6'd0, state.bulletCol};
                  fsm <= KILL;
               end else begin
                  upd <= {F_BULLET, 2'b00, 1'b1, nextRow, state.bulletCol};
               end
            end
            KILL: if (updReady) begin
               upd <= {F_BULLET, 9'd0};            // Invader gone so drop the bullet next
               fsm <= STOP;
            end
            STOP: if (updReady) begin
               updValid <= 1'b0;
               fsm      <= IDLE;
            end
            default: fsm <= IDLE;
         endcase
      end
   end

endmodule

/* shipControl.sv */
// Ship movement requests
`timescale 1ns/1ps

module shipControl import gamePkg::*; (
   input  logic         dclk,
   input  logic         rstN,
   input  logic         left,      // Debounced pulse
   input  logic         right,     // Debounced pulse
   input  gameState_t   state,
   output logic         updValid,
   output stateUpdate_t upd,
   input  logic         updReady
);

   localparam logic [COL_BITS-1:0] COL_MAX = COL_BITS'(INV_COLS - 1);

   logic [COL_BITS-1:0] target;    // Saturated neighbour column

   always_comb begin
      target = state.shipCol;
      if (left && state.shipCol != '0) begin
         target = state.shipCol - 1'b1;
      end else if (right && state.shipCol != COL_MAX) begin
         target = state.shipCol + 1'b1;
      end
   end

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         updValid <= 1'b0;
         upd      <= '0;
      end else if (updValid) begin
         if (updReady) updValid <= 1'b0;             // Record takes the move on this edge
      end else if (target != state.shipCol) begin    // Press at an edge is ignored
         updValid <= 1'b1;
         upd      <= {F_SHIP, 6'd0, target};
      end
   end

endmodule

/* buttonDebounce.sv */
// Button debouncer with press pulse
`timescale 1ns/1ps

module buttonDebounce #(
   parameter int DEBOUNCE_CYCLES = 4
) (
   input  logic dclk,
   input  logic rstN,
   input  logic button,
   output logic pressed    // One cycle per accepted rise
);

   localparam int CNT_BITS = $clog2(DEBOUNCE_CYCLES + 1);

   logic [1:0]          syncQ;      // Two-flop synchroniser
   logic                stable;     // Accepted level
   logic [CNT_BITS-1:0] holdCnt;    // Cycles the new level has held

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         syncQ   <= '0;
         stable  <= 1'b0;
         holdCnt <= '0;
         pressed <= 1'b0;
      end else begin
         syncQ   <= {syncQ[0], button};
         pressed <= 1'b0;
         if (syncQ[1] == stable) begin
            holdCnt <= '0;                           // Bounce back restarts the count
         end else if (holdCnt == CNT_BITS'(DEBOUNCE_CYCLES - 1)) begin
            stable  <= syncQ[1];                     // Level held long enough
            holdCnt <= '0;
            pressed <= syncQ[1];                     // Pulse on rise only
         end else begin
            holdCnt <= holdCnt + 1'b1;
         end
      end
   end

endmodule

/* vgaTiming.sv */
// VGA sync generator
`timescale 1ns/1ps

module vgaTiming import vgaPkg::*; #(
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BACK   = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 33
) (
   input  logic       dclk,
   input  logic       rstN,
   output screenPos_t pos,
   output logic       active,
   output logic       hsync,      // Active low
   output logic       vsync,      // Active low
   output logic       frameStart  // Pixel 0 of line 0
);

   // Region boundaries in the order active, front, sync, back
   localparam logic [POS_BITS-1:0] H_SYNC_BEG = POS_BITS'(H_ACTIVE + H_FRONT);
   localparam logic [POS_BITS-1:0] H_SYNC_END = POS_BITS'(H_ACTIVE + H_FRONT + H_SYNC);
   localparam logic [POS_BITS-1:0] H_LAST     = POS_BITS'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
   localparam logic [POS_BITS-1:0] V_SYNC_BEG = POS_BITS'(V_ACTIVE + V_FRONT);
   localparam logic [POS_BITS-1:0] V_SYNC_END = POS_BITS'(V_ACTIVE + V_FRONT + V_SYNC);
   localparam logic [POS_BITS-1:0] V_LAST     = POS_BITS'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

   logic [POS_BITS-1:0] hCount;   // Pixel counter
   logic [POS_BITS-1:0] vCount;   // Line counter

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         hCount <= '0;
         vCount <= '0;
      end else if (hCount == H_LAST) begin
         hCount <= '0;
         vCount <= (vCount == V_LAST) ? '0 : vCount + 1'b1;   // Wrap at frame end
      end else begin
         hCount <= hCount + 1'b1;
      end
   end

   //////////////////////////////////////////
   // Registered outputs kept aligned
   //////////////////////////////////////////

   always_ff @(posedge dclk or negedge rstN) begin
      if (!rstN) begin
         pos        <= '0;
         active     <= 1'b0;
         hsync      <= 1'b1;     // Idle high
         vsync      <= 1'b1;
         frameStart <= 1'b0;
      end else begin
         pos.x      <= hCount;
         pos.y      <= vCount;
         active     <= (hCount < POS_BITS'(H_ACTIVE)) && (vCount < POS_BITS'(V_ACTIVE));
         hsync      <= !((hCount >= H_SYNC_BEG) && (hCount < H_SYNC_END));
         vsync      <= !((vCount >= V_SYNC_BEG) && (vCount < V_SYNC_END));
         frameStart <= (hCount == '0) && (vCount == '0);
      end
   end

endmodule

/* gamePkg.sv */
// Game state record and update codes
package gamePkg;

   localparam int INV_COLS = 8;                          // Invader and ship columns
   localparam int COL_BITS = $clog2(INV_COLS);
   localparam int ROW_BITS = 3;                          // Eight cell rows
   localparam int N_PEERS  = 3;                          // Ship, bullet, march

   localparam logic [ROW_BITS-1:0] SHIP_ROW     = 3'd7;  // Bottom row
   localparam logic [ROW_BITS-1:0] LAUNCH_ROW   = 3'd6;  // Just above ship
   localparam logic [ROW_BITS-1:0] INV_STOP_ROW = 3'd6;  // Lowest invader row

   //////////////////////////////////////////
   // Shared record
   //////////////////////////////////////////

   typedef struct packed {
      logic [COL_BITS-1:0] shipCol;
      logic [INV_COLS-1:0] invArray;   // Bit set while invader alive
      logic [ROW_BITS-1:0] invRow;
      logic [COL_BITS-1:0] bulletCol;
      logic [ROW_BITS-1:0] bulletRow;
      logic                bulletFlying;
   } gameState_t;

   localparam gameState_t GAME_RESET = '{
      shipCol: '0, invArray: '1, invRow: '0,
      bulletCol: '0, bulletRow: '0, bulletFlying: 1'b0
   };

   // Which part of the record an update targets
   typedef enum logic [1:0] {
      F_SHIP    = 2'd0,     // value[2:0] new column
      F_BULLET  = 2'd1,     // value[6] flying, [5:3] row, [2:0] column
      F_INVROW  = 2'd2,     // value[2:0] new row
      F_INVKILL = 2'd3      // value[2:0] column to clear
   } field_t;

   typedef struct packed {
      field_t     field;
      logic [8:0] value;
   } stateUpdate_t;

endpackage

/* vgaPkg.sv */
// VGA screen types
package vgaPkg;

   localparam int POS_BITS = 10;               // Width of each screen axis

   //////////////////////////////////////////
   // Pixel position and colour
   //////////////////////////////////////////

   typedef struct packed {
      logic [POS_BITS-1:0] x;                   // Pixel within line
      logic [POS_BITS-1:0] y;                   // Line within frame
   } screenPos_t;

   // One bit per gun with red on top
   typedef logic [2:0] rgb_t;

   localparam rgb_t BLACK = 3'b000;
   localparam rgb_t RED   = 3'b100;
   localparam rgb_t GREEN = 3'b010;
   localparam rgb_t WHITE = 3'b111;

endpackage
